/* build.f */
common/jpeg_coef_pkg.sv
common/jpeg_token_pkg.sv
verilog/token_fifo.sv
rll_encoder/block_info_decode.sv
rll_encoder/coef_execute.sv
rll_encoder/token_result.sv
verilog/rll_encoder_top.sv
dv/rll_encoder_tb.sv

/* Makefile */
# Verilator simulation of the run-length encoder

TOP = rll_encoder_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/rll_encoder_tb.sv */
/*
 * Directed testbench for the run-length encoder top level.
 * Each test writes descriptors and coefficient blocks, builds the expected
 * token list from the token rules and compares what the FIFO hands out.
 * A cycle watchdog bounds the whole run.
 */
`timescale 1ns/10ps
`default_nettype none

module rll_encoder_tb import jpeg_coef_pkg::*, jpeg_token_pkg::*; ();

    localparam int num_blocks  = 21;                        // blocks over all tests
    localparam int block_gap   = 6;                         // idle cycles after a block
    localparam int wait_limit  = 4 * block_len;             // per drain
    localparam int cycle_limit = 16 + num_blocks * (block_len + 16) + 600;

    logic  clk;
    logic  rst_n;
    logic  en;
    logic  desc_stb;
    comp_t desc_comp;
    logic  desc_comp_first;
    logic  desc_color;
    logic  desc_last_in_mb;
    logic  desc_last_mcu;
    logic  desc_first_block;
    logic  coef_start;
    logic  coef_first_block;
    coef_t coef;
    logic  tok_ready;
    tok_t  tok_data;
    logic  tok_valid;
    logic  tok_overflow;

    coef_t  blk_coef [block_len];                           // stimulus for the next block
    coef_t  pred_model [comp_count];                        // reference dc predictors
    comp_t  d_comp [desc_depth];                            // descriptors as written, per test
    logic   d_cf [desc_depth];
    logic   d_color [desc_depth];
    logic   d_flb [desc_depth];
    tok_t   exp_q [$];
    tok_t   got_q [$];
    integer seed;
    int     cycle_cnt;
    int     tok_errors;
    int     flag_errors;
    int     other_errors;

    rll_encoder_top u_rll_encoder_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                              // 8 ns period
    end

    // valid and ready seen here transfer on the next rising edge
    always @(negedge clk) begin
        if (rst_n && tok_valid && tok_ready) got_q.push_back(tok_data);
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic val_t clamp_val(input int x);
        if (x > 2047) return val_t'(2047);                  // 12-bit signed limits
        if (x < -2048) return val_t'(-2048);
        return val_t'(x);
    endfunction

    function automatic tok_t dc_token(input logic color, input logic flb, input val_t d);
        return {2'b11, color, flb, d};
    endfunction

    function automatic tok_t ac_token(input logic last, input val_t v);
        return {3'b100, last, v};
    endfunction

    // run token when eob is 0, end-of-block token when 1
    function automatic tok_t zero_token(input logic eob, input int n);
        return {3'b000, eob, 6'b000000, 6'(n)};
    endfunction

    task automatic check_tok(input tok_t got, input tok_t exp, input string name);
        if (got !== exp) begin
            tok_errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            flag_errors++;
            $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // expected tokens of one block, predictor model updated as the decoder would
    task automatic add_expected(input int di);
        int   p;
        int   k;
        int   run_len;
        val_t d;
        p = d_cf[di] ? 0 : int'(pred_model[d_comp[di]]);
        d = clamp_val(int'(blk_coef[0]) - p);
        pred_model[d_comp[di]] = coef_t'(p + int'(d));      // restored, not raw
        exp_q.push_back(dc_token(d_color[di], d_flb[di], d));
        run_len = 0;
        for (k = 1; k < block_len; k++) begin
            if (blk_coef[k] == '0) begin
                run_len++;
            end else begin
                if (run_len > 0) exp_q.push_back(zero_token(1'b0, run_len));
                exp_q.push_back(ac_token(k == block_len - 1, clamp_val(int'(blk_coef[k]))));
                run_len = 0;
            end
        end
        if (run_len > 0) exp_q.push_back(zero_token(1'b1, run_len)); // trailing zeros
    endtask

    task automatic write_desc(input int di, input comp_t c, input logic cf, input logic color,
                              input logic lim, input logic lmcu, input logic fb);
        d_comp[di]  = c;
        d_cf[di]    = cf;
        d_color[di] = color;
        d_flb[di]   = lim && lmcu;                          // last block of the frame
        @(posedge clk);
        desc_stb         <= 1'b1;
        desc_comp        <= c;
        desc_comp_first  <= cf;
        desc_color       <= color;
        desc_last_in_mb  <= lim;
        desc_last_mcu    <= lmcu;
        desc_first_block <= fb;
        @(posedge clk);
        desc_stb         <= 1'b0;
        desc_first_block <= 1'b0;
    endtask

    task automatic send_block(input int di, input logic rewind);
        int i;
        add_expected(di);
        @(posedge clk);
        coef_start       <= 1'b1;
        coef_first_block <= rewind;                         // back to frame start
        for (i = 0; i < block_len; i++) begin
            @(posedge clk);
            coef_start       <= 1'b0;
            coef_first_block <= 1'b0;
            coef             <= blk_coef[i];                // dc then 63 ac, no gaps
        end
        @(posedge clk);
        coef <= '0;
        repeat (block_gap) @(posedge clk);
    endtask

    task automatic clear_block(input int dc);
        int k;
        blk_coef[0] = coef_t'(dc);
        for (k = 1; k < block_len; k++) blk_coef[k] = '0;
    endtask

    task automatic fill_random(input logic dense);
        int k;
        int v;
        blk_coef[0] = coef_t'($random(seed) % 1024);
        for (k = 1; k < block_len; k++) begin
            v = $random(seed) % 4096;                       // reaches past 12 bits
            if (dense && v == 0) v = 1;
            if (!dense && ($random(seed) & 3) != 0) v = 0;  // about one in four nonzero
            blk_coef[k] = coef_t'(v);
        end
    endtask

    task automatic flush_dut();
        @(posedge clk);
        en <= 1'b0;                                         // clears pointers and fifo
        @(posedge clk);
        en <= 1'b1;
        @(posedge clk);
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic wait_tokens(input int n);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (got_q.size() < n) begin
            other_errors++;
            $display("timed out waiting for tokens: %0d of %0d arrived", got_q.size(), n);
        end
        repeat (4) @(posedge clk);                          // catch stray extra tokens
    endtask

    task automatic compare_tokens(input string test);
        int i;
        if (got_q.size() != exp_q.size()) begin
            other_errors++;
            $display("%s: %0d tokens received but %0d expected", test, got_q.size(),
                     exp_q.size());
        end
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++)
            check_tok(got_q[i], exp_q[i], $sformatf("%s tok_data[%0d]", test, i));
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic wait_and_compare(input string test);
        wait_tokens(exp_q.size());
        compare_tokens(test);
        check_flag(tok_overflow, 1'b0, "tok_overflow");
    endtask

    task automatic test_dc_prediction();
        flush_dut();
        write_desc(0, 3'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        write_desc(1, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        clear_block(100);                                   // first of comp, dc as is
        blk_coef[1] = coef_t'(5);
        send_block(0, 1'b0);
        clear_block(130);                                   // diff against 100
        blk_coef[1] = coef_t'(-3);
        blk_coef[2] = coef_t'(7);
        send_block(1, 1'b0);
        wait_and_compare("dc_prediction");
    endtask

    task automatic test_saturation();
        flush_dut();
        write_desc(0, 3'd1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        write_desc(1, 3'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        write_desc(2, 3'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        clear_block(4000);                                  // diff over +2047
        blk_coef[1] = coef_t'(3000);
        blk_coef[2] = coef_t'(-3500);
        blk_coef[5] = coef_t'(4095);
        blk_coef[6] = coef_t'(-4096);
        blk_coef[7] = coef_t'(2047);
        blk_coef[8] = coef_t'(-2048);
        blk_coef[9] = coef_t'(2048);
        send_block(0, 1'b0);
        clear_block(-4000);                                 // diff under -2048
        blk_coef[3] = coef_t'(-2049);
        send_block(1, 1'b0);
        clear_block(10);                                    // shows restored predictor
        send_block(2, 1'b0);
        wait_and_compare("saturation");
    endtask

    task automatic test_runs();
        flush_dut();
        write_desc(0, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        write_desc(1, 3'd2, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        write_desc(2, 3'd2, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        clear_block(-20);
        blk_coef[1]  = coef_t'(1);
        blk_coef[4]  = coef_t'(-1);
        blk_coef[10] = coef_t'(300);
        blk_coef[40] = coef_t'(-77);                        // 23 trailing zeros
        send_block(0, 1'b0);
        clear_block(-25);
        blk_coef[2]  = coef_t'(9);
        blk_coef[63] = coef_t'(-12);                        // last coef set, no eob
        send_block(1, 1'b0);
        clear_block(0);                                     // all ac zero
        send_block(2, 1'b0);
        wait_and_compare("runs");
    endtask

    task automatic test_desc_flags();
        int di;
        flush_dut();
        write_desc(0, 3'd3, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);  // ahead of the frame
        write_desc(1, 3'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);  // frame start
        write_desc(2, 3'd1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        write_desc(3, 3'd0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        write_desc(4, 3'd2, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        write_desc(5, 3'd1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0);  // last block of frame
        fill_random(1'b0);
        send_block(0, 1'b0);
        for (di = 1; di <= 5; di++) begin
            fill_random(1'b0);
            send_block(di, 1'b0);
        end
        for (di = 1; di <= 5; di++) begin                   // replay the frame
            fill_random(1'b0);
            send_block(di, di == 1);
        end
        wait_and_compare("desc_flags");
    endtask

    task automatic test_back_pressure();
        int waited;
        flush_dut();
        write_desc(0, 3'd5, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        fill_random(1'b1);
        fork
            send_block(0, 1'b0);
            begin
                repeat (20) @(posedge clk);
                tok_ready <= 1'b0;                          // short stall mid block
                repeat (12) @(posedge clk);
                tok_ready <= 1'b1;
            end
        join
        wait_and_compare("short_stall");
        flush_dut();
        write_desc(0, 3'd6, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        fill_random(1'b1);
        @(posedge clk);
        tok_ready <= 1'b0;                                  // held through the block
        send_block(0, 1'b0);
        waited = 0;
        while (!tok_overflow && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        check_flag(tok_overflow, 1'b1, "tok_overflow");
        // output word plus a full buffer survive, the rest is dropped
        while (exp_q.size() > tok_depth + 1) void'(exp_q.pop_back());
        @(posedge clk);
        tok_ready <= 1'b1;
        wait_tokens(exp_q.size());
        compare_tokens("long_stall");
    endtask

    initial begin
        seed             = 32'h3a44_6716;
        tok_errors       = 0;
        flag_errors      = 0;
        other_errors     = 0;
        rst_n            = 1'b0;
        en               = 1'b0;
        desc_stb         = 1'b0;
        desc_comp        = '0;
        desc_comp_first  = 1'b0;
        desc_color       = 1'b0;
        desc_last_in_mb  = 1'b0;
        desc_last_mcu    = 1'b0;
        desc_first_block = 1'b0;
        coef_start       = 1'b0;
        coef_first_block = 1'b0;
        coef             = '0;
        tok_ready        = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        en    <= 1'b1;
        @(posedge clk);
        test_dc_prediction();
        test_saturation();
        test_runs();
        test_desc_flags();
        test_back_pressure();
        $display("errors: token %0d, flag %0d, other %0d", tok_errors, flag_errors,
                 other_errors);
        if (tok_errors + flag_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/rll_encoder_top.sv */
/*
 * Run-length front end of the JPEG entropy coder.
 * decode -> execute -> result -> token FIFO; wiring only.
 * A dc token is pushed 3 cycles after its dc coefficient.
 */
`timescale 1ns/10ps
`default_nettype none

module rll_encoder_top import jpeg_coef_pkg::*, jpeg_token_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  logic  desc_stb,
    input  comp_t desc_comp,
    input  logic  desc_comp_first,
    input  logic  desc_color,
    input  logic  desc_last_in_mb,
    input  logic  desc_last_mcu,
    input  logic  desc_first_block,
    input  logic  coef_start,
    input  logic  coef_first_block,
    input  coef_t coef,
    input  logic  tok_ready,
    output tok_t  tok_data,
    output logic  tok_valid,
    output logic  tok_overflow
);

    val_t  val;
    coef_t dc_raw;
    idx_t  idx;
    logic  is_dc;
    logic  active;
    comp_t comp;
    logic  comp_first;
    logic  color;
    logic  frame_last_block;
    val_t  dc_diff;
    val_t  ac_val;
    idx_t  run;
    logic  dc_stb;
    logic  ac_nz_stb;
    logic  run_stb;
    logic  eob_stb;
    logic  last_coef;
    logic  push;
    tok_t  push_data;

    block_info_decode u_decode (
        .clk, .rst_n, .en,
        .desc_stb, .desc_first_block, .desc_comp, .desc_comp_first,
        .desc_color, .desc_last_in_mb, .desc_last_mcu,
        .coef_start, .coef_first_block, .coef,
        .val, .dc_raw, .idx, .is_dc, .active,
        .comp, .comp_first, .color, .frame_last_block
    );

    coef_execute u_execute (
        .clk, .rst_n, .en,
        .val, .dc_raw, .idx, .is_dc, .active, .comp, .comp_first,
        .dc_diff, .ac_val, .run,
        .dc_stb, .ac_nz_stb, .run_stb, .eob_stb, .last_coef
    );

    token_result u_result (
        .clk, .rst_n,
        .dc_diff, .ac_val, .run,
        .dc_stb, .ac_nz_stb, .run_stb, .eob_stb,
        .color, .frame_last_block, .last_coef,
        .push, .push_data
    );

    token_fifo u_fifo (
        .clk, .rst_n, .en,
        .push, .push_data, .tok_ready,
        .tok_valid, .tok_data, .tok_overflow
    );

endmodule

`default_nettype wire

/* rll_encoder/token_result.sv */
/*
 * Token forming stage.
 * Packs whichever execute strobe is high into a 16-bit token and
 * registers it together with push. Execute never raises two strobes
 * in one cycle, so the priority below only orders the mux.
 */
`timescale 1ns/10ps
`default_nettype none

module token_result import jpeg_coef_pkg::*, jpeg_token_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  val_t dc_diff,
    input  val_t ac_val,
    input  idx_t run,
    input  logic dc_stb,
    input  logic ac_nz_stb,
    input  logic run_stb,
    input  logic eob_stb,
    input  logic color,
    input  logic frame_last_block,
    input  logic last_coef,
    output logic push,
    output tok_t push_data
);

    logic any_stb;

    assign any_stb = dc_stb || ac_nz_stb || run_stb || eob_stb;

    always_ff @(posedge clk) begin
        if (any_stb) begin
            if (dc_stb)
                push_data <= {tok_dc, color, frame_last_block, dc_diff};
            else if (run_stb)
                push_data <= {tok_run, {tok_pad_w{1'b0}}, tok_run_w'(run)};
            else if (eob_stb)
                push_data <= {tok_eob, {tok_pad_w{1'b0}}, tok_run_w'(run)}; // trailing zeros
            else
                push_data <= {tok_ac, last_coef, ac_val};   // nonzero ac
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) push <= 1'b0;
        else        push <= any_stb;                        // en gating done upstream
    end

endmodule

`default_nettype wire

/* rll_encoder/coef_execute.sv */
/*
 * DC prediction and zero-run counting.
 * DC: predictor read on the dc cycle, limited difference registered next,
 * restored predictor written back one cycle later so the decoder tracks.
 * AC: run_stb is raised in the cycle a nonzero ac meets a pending run,
 * its ac_nz_stb follows registered; trailing zeros give eob_stb.
 */
`timescale 1ns/10ps
`default_nettype none

module coef_execute import jpeg_coef_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  val_t  val,
    input  coef_t dc_raw,
    input  idx_t  idx,
    input  logic  is_dc,
    input  logic  active,
    input  comp_t comp,
    input  logic  comp_first,
    output val_t  dc_diff,
    output val_t  ac_val,
    output idx_t  run,
    output logic  dc_stb,
    output logic  ac_nz_stb,
    output logic  run_stb,
    output logic  eob_stb,
    output logic  last_coef
);

    coef_t                      dc_mem [comp_count];        // per-component predictor
    coef_t                      pred;
    coef_t                      pred_r;
    comp_t                      comp_r;
    logic signed [coef_width:0] diff_full;                  // one bit wider, no wrap
    idx_t                       run_cnt;
    logic                       ac_cycle;
    logic                       nz;

    assign pred      = comp_first ? '0 : dc_mem[comp];      // first of component starts at 0
    assign diff_full = dc_raw - pred;
    assign ac_cycle  = active && !is_dc;
    assign nz        = (val != '0);
    assign run       = run_cnt;                             // run or trailing count
    // emitted one cycle ahead of the ac token it precedes
    assign run_stb   = en && ac_cycle && nz && (run_cnt != '0);

    always_ff @(posedge clk) begin
        if (active && is_dc) begin
            pred_r  <= pred;
            comp_r  <= comp;
            dc_diff <= sat_val(diff_full);
        end
        // restore so that predictor + coded diff is exactly what the decoder sees
        if (dc_stb) dc_mem[comp_r] <= pred_r + coef_t'(dc_diff);
        if (ac_cycle) begin
            ac_val    <= val;
            last_coef <= (idx == last_idx);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_stb <= 1'b0; ac_nz_stb <= 1'b0; eob_stb <= 1'b0;
            run_cnt <= '0;
        end else if (!en) begin
            dc_stb <= 1'b0; ac_nz_stb <= 1'b0; eob_stb <= 1'b0;
            run_cnt <= '0;
        end else begin
            dc_stb    <= active && is_dc;
            ac_nz_stb <= ac_cycle && nz;
            eob_stb   <= ac_cycle && !nz && (idx == last_idx); // run_cnt then holds trailing count
            if (ac_cycle && !nz) run_cnt <= run_cnt + 1'b1; // max 63 fits
            else                 run_cnt <= '0;             // dc, nonzero ac or idle
        end
    end

endmodule

`default_nettype wire

/* rll_encoder/block_info_decode.sv */
/*
 * Input conditioning for the run-length encoder.
 * Stores per-block descriptors in a small ring, selects the current one
 * on coef_start (or rewinds to the frame start), saturates coefficients
 * to 12 bits and tracks the coefficient index. Outputs lag the input by 1.
 */
`timescale 1ns/10ps
`default_nettype none

module block_info_decode import jpeg_coef_pkg::*, jpeg_token_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  logic  desc_stb,
    input  logic  desc_first_block,                         // mark frame start at this slot
    input  comp_t desc_comp,
    input  logic  desc_comp_first,
    input  logic  desc_color,
    input  logic  desc_last_in_mb,
    input  logic  desc_last_mcu,
    input  logic  coef_start,                               // one cycle ahead of dc
    input  logic  coef_first_block,
    input  coef_t coef,
    output val_t  val,
    output coef_t dc_raw,
    output idx_t  idx,
    output logic  is_dc,
    output logic  active,
    output comp_t comp,
    output logic  comp_first,
    output logic  color,
    output logic  frame_last_block
);

    logic [desc_width-1:0] desc_mem [desc_depth];
    logic [desc_width-1:0] desc_rd;
    logic [desc_ptr_w-1:0] wr_ptr;
    logic [desc_ptr_w-1:0] rd_ptr;
    logic [desc_ptr_w-1:0] frame_ptr;                       // slot of first block in frame
    logic                  start_d;                         // high on the dc input cycle

    assign desc_rd          = desc_mem[rd_ptr];             // combinational read
    assign comp             = desc_rd[2:0];
    assign comp_first       = desc_rd[3];
    assign color            = desc_rd[4];
    assign frame_last_block = desc_rd[5] && desc_rd[6];     // last in mb of last mcu

    always_ff @(posedge clk) begin
        if (desc_stb)
            desc_mem[wr_ptr] <= {desc_last_mcu, desc_last_in_mb, desc_color,
                                 desc_comp_first, desc_comp};
        val    <= sat_val({coef[coef_width-1], coef});      // sign-extend then limit
        dc_raw <= coef;                                     // full value for dc prediction
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0; frame_ptr <= '0; rd_ptr <= '1;
            start_d <= 1'b0; is_dc <= 1'b0; active <= 1'b0; idx <= '0;
        end else if (!en) begin
            wr_ptr <= '0; frame_ptr <= '0; rd_ptr <= '1;    // first advance lands on slot 0
            start_d <= 1'b0; is_dc <= 1'b0; active <= 1'b0; idx <= '0;
        end else begin
            if (desc_stb) wr_ptr <= wr_ptr + 1'b1;
            if (desc_stb && desc_first_block) frame_ptr <= wr_ptr;
            if (coef_start)
                rd_ptr <= coef_first_block ? frame_ptr : rd_ptr + 1'b1;
            start_d <= coef_start;
            is_dc   <= start_d;
            if (start_d) begin
                active <= 1'b1;                             // dc at index 0
                idx    <= '0;
            end else if (active) begin
                if (idx == last_idx) active <= 1'b0;        // block done after 63rd ac
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/token_fifo.sv */
/*
 * Token FIFO between the run-length stage and a Huffman consumer.
 * Circular buffer feeding a registered output word; a push into an
 * empty FIFO shows on tok_data the next cycle. Full pushes are
 * dropped and latch tok_overflow until reset or en low.
 */
`timescale 1ns/10ps
`default_nettype none

module token_fifo import jpeg_token_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic en,                                        // low flushes the fifo
    input  logic push,
    input  tok_t push_data,
    input  logic tok_ready,
    output logic tok_valid,
    output tok_t tok_data,
    output logic tok_overflow
);

    tok_t                 mem [tok_depth];
    logic [tok_ptr_w-1:0] wr_ptr;
    logic [tok_ptr_w-1:0] rd_ptr;
    logic [tok_cnt_w-1:0] count;                            // words in mem, not the output reg
    logic                 out_free;
    logic                 buf_empty;
    logic                 buf_full;
    logic                 load;
    logic                 bypass;
    logic                 mem_wr;

    assign out_free  = !tok_valid || tok_ready;             // output reg empty or draining
    assign buf_empty = (count == '0);
    assign buf_full  = (count == tok_cnt_w'(tok_depth));
    assign load      = out_free && !buf_empty;              // head of mem -> output reg
    assign bypass    = out_free && buf_empty && push;       // straight into output reg
    assign mem_wr    = push && !bypass && (!buf_full || load);

    always_ff @(posedge clk) begin
        if (mem_wr) mem[wr_ptr] <= push_data;
        if (bypass)    tok_data <= push_data;
        else if (load) tok_data <= mem[rd_ptr];             // old slot read even when full
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0; rd_ptr <= '0; count <= '0;
            tok_valid <= 1'b0; tok_overflow <= 1'b0;
        end else if (!en) begin
            wr_ptr <= '0; rd_ptr <= '0; count <= '0;
            tok_valid <= 1'b0; tok_overflow <= 1'b0;
        end else begin
            if (mem_wr) wr_ptr <= wr_ptr + 1'b1;            // wraps at depth
            if (load)   rd_ptr <= rd_ptr + 1'b1;
            count <= count + tok_cnt_w'(mem_wr) - tok_cnt_w'(load);
            if (bypass || load) tok_valid <= 1'b1;
            else if (tok_ready) tok_valid <= 1'b0;
            if (push && !bypass && !mem_wr) tok_overflow <= 1'b1; // dropped token
        end
    end

endmodule

`default_nettype wire

/* common/jpeg_token_pkg.sv */
/*
 * Token-side definitions: 16-bit token word, kind codes, field widths,
 * token FIFO depth and the descriptor store geometry.
 * Formats, msb first:
 *   dc  : 1 1 color frame_last dc_diff[11:0]
 *   ac  : 1 0 0 last_coef ac[11:0]
 *   run : 0 0 0 0 000000 run[5:0]
 *   eob : 0 0 0 1 000000 trailing[5:0]
 */
`default_nettype none

package jpeg_token_pkg;

    localparam int tok_width = 16;
    typedef logic [tok_width-1:0] tok_t;

    // kind codes, left-aligned in the token
    localparam logic [1:0] tok_dc  = 2'b11;                 // followed by color, frame_last
    localparam logic [2:0] tok_ac  = 3'b100;                // followed by last_coef
    localparam logic [3:0] tok_run = 4'b0000;
    localparam logic [3:0] tok_eob = 4'b0001;

    localparam int tok_pad_w = 6;                           // zero field in run/eob tokens
    localparam int tok_run_w = 6;                           // run count field

    // token fifo
    localparam int tok_depth = 16;
    localparam int tok_ptr_w = $clog2(tok_depth);
    localparam int tok_cnt_w = $clog2(tok_depth) + 1;       // holds 0..depth

    // descriptor store
    localparam int desc_depth = 8;
    localparam int desc_ptr_w = $clog2(desc_depth);
    localparam int desc_width = 7;                          // last_mcu, last_in_mb, color, first, comp[2:0]

endpackage

`default_nettype wire

/* common/jpeg_coef_pkg.sv */
/*
 * Coefficient-side definitions for the JPEG run-length front end.
 * Widths, block length, predictor slots and the 12-bit saturation
 * shared by the decode and execute stages.
 */
`default_nettype none

package jpeg_coef_pkg;

    localparam int coef_width = 13;                         // quantized input, signed
    localparam int val_width  = 12;                         // encodable range after limiting
    localparam int block_len  = 64;                         // dc + 63 ac per block
    localparam int comp_count = 8;                          // dc predictor slots

    localparam int val_max = 2 ** (val_width - 1) - 1;      // +2047
    localparam int val_min = -(2 ** (val_width - 1));       // -2048

    typedef logic signed [coef_width-1:0]          coef_t;
    typedef logic signed [val_width-1:0]           val_t;
    typedef logic [$clog2(block_len)-1:0]          idx_t;   // index, also run length
    typedef logic [$clog2(comp_count)-1:0]         comp_t;

    localparam idx_t last_idx = idx_t'(block_len - 1);      // 63rd ac

    // clamp a one-bit-wider signed value into the 12-bit range
    function automatic val_t sat_val(input logic signed [coef_width:0] x);
        val_t r;
        if (x > val_max)      r = val_t'(val_max);
        else if (x < val_min) r = val_t'(val_min);
        else                  r = x[val_width-1:0];
        return r;
    endfunction

endpackage

`default_nettype wire
